/* Makefile */
# Verilator build and run of the front end testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_frontend
FILELIST  ?= all.f
LOG       ?= sim.log
FAIL_MSG  := Checks failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
verilog/frontend_pkg.sv
verilog/branch_predictor.sv
verilog/branch_target_buffer.sv
verilog/inst_decoder.sv
verilog/fetch_decode_stage.sv
bench/frontend_assertions.sv
bench/frontend_checker.sv
bench/tb_frontend.sv

/* bench/frontend_assertions.sv */
// bound to fetch_decode_stage; sees the pc register directly
module frontend_assertions (
	input logic        clock,
	input logic        reset,
	input logic [31:0] icache_addr,
	input logic [31:0] pc_reg,
	input logic        id_valid,
	input logic        result_valid,
	input logic        result_mis_pred
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;                      // read by the bench at the end

	// first edge out of reset sees pc 0
	a_reset_addr: assert property (@(posedge clock) $fell(reset) |-> icache_addr == 32'd0)
		else begin
			fail_count++;
			$error("icache_addr not zero after reset");
		end

	// stall without redirect keeps the pc
	a_stall_hold: assert property (@(posedge clock) disable iff (reset)
		(!id_valid && !(result_valid && result_mis_pred)) |=> $stable(pc_reg))
		else begin
			fail_count++;
			$error("pc moved during a stall");
		end

	// aligned targets and pc + 4 keep the pc on a word boundary
	a_aligned: assert property (@(posedge clock) disable iff (reset) pc_reg[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("pc not word aligned");
		end

endmodule

bind fetch_decode_stage frontend_assertions u_assertions (
	.clock(clock), .reset(reset), .icache_addr(icache_addr), .pc_reg(pc_reg),
	.id_valid(id_valid), .result_valid(result_valid), .result_mis_pred(result_mis_pred)
);

/* bench/frontend_checker.sv */
// samples on the falling edge, half a cycle after the bench drives inputs
module frontend_checker (
	input  logic        clock,
	input  logic        reset,
	input  logic [31:0] mem_word,           // bench copy of the word at icache_addr
	input  logic        icache_valid,
	input  logic        rob_full,
	input  logic [3:0]  rs_full,
	input  logic        result_valid,
	input  logic        result_mis_pred,
	input  logic [31:0] result_target_pc,
	input  logic        probe_en,           // directed prediction check this cycle
	input  logic [31:0] probe_npc,
	input  logic        probe_cond,
	input  logic [31:0] icache_addr,
	input  logic        id_valid,
	input  logic [31:0] id_inst,
	input  logic [31:0] id_pc,
	input  logic [31:0] id_npc,
	input  logic [1:0]  id_opa_select,
	input  logic [2:0]  id_opb_select,
	input  logic [3:0]  id_alu_func,
	input  logic [1:0]  id_fu_type,
	input  logic [4:0]  id_rs1_idx,
	input  logic [4:0]  id_rs2_idx,
	input  logic [4:0]  id_dest_idx,
	input  logic        id_rd_mem,
	input  logic        id_wr_mem,
	input  logic        id_cond_branch,
	input  logic        id_uncond_branch,
	input  logic        id_csr_op,
	input  logic        id_halt,
	input  logic        id_illegal,
	input  logic        id_local_taken,
	input  logic        id_global_taken,
	input  logic        id_branch_prediction,
	output int          error_count,
	output int          check_count
);
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [1:0] opa;
		logic [2:0] opb;
		logic [3:0] alu;
		logic [1:0] fu;
		logic       dest, rd, wr, cond, uncond, csr, halt, ill;
	} decoded_t;

	logic        was_reset = 1'b1;
	logic        have_prev = 1'b0;
	logic        prev_valid, prev_redirect, prev_jump;
	logic [31:0] prev_addr, prev_target;

	initial begin
		error_count = 0;
		check_count = 0;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference decode, by instruction class
	function automatic decoded_t ref_decode(input logic [31:0] inst);
		decoded_t d;
		logic [6:0] op;
		logic [2:0] f3;
		logic [6:0] f7;
		op = inst[6:0];
		f3 = inst[14:12];
		f7 = inst[31:25];
		d = '0;
		d.opa = frontend_pkg::opa_is_rs1;
		d.opb = frontend_pkg::opb_is_rs2;
		d.alu = frontend_pkg::alu_add;
		d.fu = frontend_pkg::fu_alu;
		if (op == frontend_pkg::op_lui || op == frontend_pkg::op_auipc) begin
			d.opa = (op == frontend_pkg::op_lui) ? frontend_pkg::opa_is_zero : frontend_pkg::opa_is_pc;
			d.opb = frontend_pkg::opb_is_u_imm;
			d.dest = 1;
		end else if (op == frontend_pkg::op_jal) begin
			d.opa = frontend_pkg::opa_is_pc;
			d.opb = frontend_pkg::opb_is_j_imm;
			d.fu = frontend_pkg::fu_branch;
			{d.uncond, d.dest} = 2'b11;
		end else if (op == frontend_pkg::op_jalr) begin
			d.opb = frontend_pkg::opb_is_i_imm;
			d.fu = frontend_pkg::fu_branch;
			{d.uncond, d.dest} = 2'b11;
			d.ill = f3 != 0;
		end else if (op == frontend_pkg::op_branch) begin
			d.opa = frontend_pkg::opa_is_pc;
			d.opb = frontend_pkg::opb_is_b_imm;
			d.fu = frontend_pkg::fu_branch;
			d.cond = 1;
			d.ill = f3 inside {3'd2, 3'd3};
		end else if (op == frontend_pkg::op_load) begin
			d.opb = frontend_pkg::opb_is_i_imm;
			d.fu = frontend_pkg::fu_mem;
			{d.rd, d.dest} = 2'b11;
			d.ill = f3 inside {3'd3, 3'd6, 3'd7};   // lb lh lw lbu lhu only
		end else if (op == frontend_pkg::op_store) begin
			d.opb = frontend_pkg::opb_is_s_imm;
			d.fu = frontend_pkg::fu_mem;
			d.wr = 1;
			d.ill = f3 > 3'd2;                      // sb sh sw only
		end else if (op == frontend_pkg::op_imm || op == frontend_pkg::op_reg) begin
			d.dest = 1;
			if (op == frontend_pkg::op_imm)
				d.opb = frontend_pkg::opb_is_i_imm;
			case (f3)
				3'd0: d.alu = (op == frontend_pkg::op_reg && f7[5]) ? frontend_pkg::alu_sub
					: frontend_pkg::alu_add;
				3'd1: d.alu = frontend_pkg::alu_sll;
				3'd2: d.alu = frontend_pkg::alu_slt;
				3'd3: d.alu = frontend_pkg::alu_sltu;
				3'd4: d.alu = frontend_pkg::alu_xor;
				3'd5: d.alu = f7[5] ? frontend_pkg::alu_sra : frontend_pkg::alu_srl;
				3'd6: d.alu = frontend_pkg::alu_or;
				3'd7: d.alu = frontend_pkg::alu_and;
			endcase
			if (op == frontend_pkg::op_reg && f7 == 7'h01)
				d.fu = frontend_pkg::fu_mult;       // M extension
			else if (op == frontend_pkg::op_reg || f3 == 3'd1 || f3 == 3'd5) begin
				// only sub and sra/srai may carry funct7 0x20
				if (f7 == 7'h20)
					d.ill = !(f3 == 3'd5 || (f3 == 3'd0 && op == frontend_pkg::op_reg));
				else
					d.ill = f7 != 7'h00;
			end
		end else if (op == frontend_pkg::op_system) begin
			if (f3 == 0) begin
				d.halt = inst[31:21] == 0 && inst[19:7] == 0; // ecall, ebreak
				d.ill = !d.halt;
			end else begin
				{d.csr, d.dest} = 2'b11;
				d.ill = f3 == 3'd4;
			end
		end else
			d.ill = 1;
		if (d.ill)
			{d.rd, d.wr, d.cond, d.uncond, d.dest, d.csr} = '0;
		return d;
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		if (exp !== act) begin
			error_count++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// comparing process
	always @(negedge clock) begin
		decoded_t e;
		logic     exp_valid;
		if (reset) begin
			was_reset = 1;
			have_prev = 0;
		end else begin
			if (was_reset) begin
				compare("reset_addr", 32'd0, icache_addr);
				compare("reset_pc", 32'd0, id_pc);
				// fresh counters are weakly not taken, btb empty
				compare("reset_pred", 3'b000,
					{id_local_taken, id_global_taken, id_branch_prediction});
			end
			e = ref_decode(mem_word);
			compare("inst", mem_word, id_inst);
			compare("opa_select", e.opa, id_opa_select);
			compare("opb_select", e.opb, id_opb_select);
			compare("alu_func", e.alu, id_alu_func);
			compare("fu_type", e.fu, id_fu_type);
			compare("rs1_idx", mem_word[19:15], id_rs1_idx);
			compare("rs2_idx", mem_word[24:20], id_rs2_idx);
			compare("dest_idx", e.dest ? mem_word[11:7] : 5'd0, id_dest_idx);
			compare("mem_flags", {e.rd, e.wr}, {id_rd_mem, id_wr_mem});
			compare("branch_flags", {e.cond, e.uncond}, {id_cond_branch, id_uncond_branch});
			compare("sys_flags", {e.csr, e.halt, e.ill}, {id_csr_op, id_halt, id_illegal});
			exp_valid = icache_valid && !(result_valid && result_mis_pred) && !rob_full
				&& !rs_full[e.fu];
			compare("id_valid", exp_valid, id_valid);
			if (have_prev) begin
				if (prev_redirect)
					compare("redirect_addr", {prev_target[31:2], 2'b00}, icache_addr);
				else if (!prev_valid)
					compare("stall_addr", prev_addr, icache_addr);
				else if (!prev_jump)
					compare("next_addr", prev_addr + 32'd4, icache_addr);
			end
			if (probe_en) begin
				if (probe_cond) begin
					compare("learned_branch", 2'b11, {id_cond_branch, id_branch_prediction});
					compare("learned_local", 1'b1, id_local_taken); // history 1111 saturated
				end else
					compare("jump_flag", 1'b1, id_uncond_branch);
				compare("predicted_npc", probe_npc, id_npc);
			end
			prev_addr = icache_addr;
			prev_valid = id_valid;
			prev_redirect = result_valid && result_mis_pred;
			prev_target = result_target_pc;
			prev_jump = e.cond || e.uncond;
			have_prev = 1;
			was_reset = 0;
		end
	end

endmodule

/* bench/tb_frontend.sv */
// cache model covers 1 KiB, so higher address bits alias onto it
module tb_frontend;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int random_cycles = 2000;
	localparam int directed_cycles = 60;
	localparam int timeout_cycles = (2 * 4 + random_cycles + directed_cycles) * 12 / 10;
	localparam logic [31:0] branch_x = 32'h100, target_t = 32'h300;
	localparam logic [31:0] jal_y = 32'h184, target_j = 32'h340;

	logic clock = 0, reset;
	logic rob_full, icache_valid, result_valid, result_mis_pred;
	logic [3:0] rs_full;
	logic [31:0] icache_data, icache_addr, result_pc, result_target_pc;
	logic result_cond_branch, result_uncond_branch, result_taken;
	logic result_local_taken, result_global_taken;
	logic probe_en, probe_cond;
	logic [31:0] probe_npc;
	logic [31:0] mem [256];                 // word array, index addr[9:2]
	logic [31:0] mem_word;
	logic [31:0] lcg_state = 32'd49;
	int cycle_count = 0;
	int error_count, check_count;
	int total_errors;

	// decoded packet from the dut
	logic        id_valid;
	logic [31:0] id_inst, id_pc, id_npc;
	logic [1:0]  id_opa_select;
	logic [2:0]  id_opb_select;
	logic [3:0]  id_alu_func;
	logic [1:0]  id_fu_type;
	logic [4:0]  id_rs1_idx, id_rs2_idx, id_dest_idx;
	logic        id_rd_mem, id_wr_mem, id_cond_branch, id_uncond_branch;
	logic        id_csr_op, id_halt, id_illegal;
	logic        id_local_taken, id_global_taken, id_branch_prediction;

	always #5 clock = ~clock;

	assign mem_word = mem[icache_addr[9:2]];
	assign icache_data = mem_word;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// mostly legal opcodes with random fields, some raw words
	function automatic logic [31:0] make_inst();
		logic [6:0] ops [10] = '{frontend_pkg::op_lui, frontend_pkg::op_auipc,
			frontend_pkg::op_jal, frontend_pkg::op_jalr, frontend_pkg::op_branch,
			frontend_pkg::op_load, frontend_pkg::op_store, frontend_pkg::op_imm,
			frontend_pkg::op_reg, frontend_pkg::op_system};
		logic [31:0] r, w;
		r = lcg_next();
		w = lcg_next();
		if (r[31:28] > 4'd11)
			return w;                            // raw, likely illegal
		w[6:0] = ops[r[27:24] % 10];
		if (r[23:22] != 0)
			w[31:25] = (r[21:20] == 0) ? 7'h01 : {1'b0, r[20], 5'b0}; // 0, 0x20, M
		return w;
	endfunction

	task automatic drive_random();
		logic [31:0] r;
		r = lcg_next();
		icache_valid <= r[31:29] != 0;
		rob_full <= r[28:26] == 0;
		rs_full <= {r[25:24] == 0, r[23:22] == 0, r[21:20] == 0, r[19:18] == 0};
		result_valid <= r[17:16] == 0;
		result_mis_pred <= r[15:14] == 0;
		result_cond_branch <= r[13];
		result_uncond_branch <= r[12] && !r[13];
		result_taken <= r[11];
		{result_local_taken, result_global_taken} <= r[10:9];
		r = lcg_next();
		result_pc <= {22'd0, r[31:24], 2'b00};
		result_target_pc <= {22'd0, r[23:16], 2'b00};
	endtask

	task automatic quiet_inputs();
		{icache_valid, rob_full, rs_full} <= {1'b1, 1'b0, 4'b0};
		{result_valid, result_mis_pred, result_cond_branch, result_uncond_branch} <= '0;
		{result_taken, result_local_taken, result_global_taken, probe_en} <= '0;
	endtask

	task automatic redirect_to(input logic [31:0] target);
		@(posedge clock);
		{result_valid, result_mis_pred, result_target_pc} <= {2'b11, target};
		{result_cond_branch, result_uncond_branch, result_taken} <= '0;
	endtask

	task automatic resolve_taken(input logic [31:0] pc, input logic [31:0] target,
			input logic cond);
		@(posedge clock);
		{result_valid, result_mis_pred, result_taken} <= 3'b101;
		{result_cond_branch, result_uncond_branch} <= {cond, !cond};
		{result_local_taken, result_global_taken} <= 2'b11;
		{result_pc, result_target_pc} <= {pc, target};
	endtask

	task automatic probe_next(input logic [31:0] npc, input logic cond);
		@(posedge clock);
		quiet_inputs();
		{probe_en, probe_npc, probe_cond} <= {1'b1, npc, cond};
		@(posedge clock);
		probe_en <= 0;
	endtask

	fetch_decode_stage u_dut (.*);

	frontend_checker u_checker (.*);

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("simulation timed out after %0d cycles", cycle_count);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		reset = 1;
		result_pc = 0;
		result_target_pc = 0;
		probe_npc = 0;
		probe_cond = 0;
		{icache_valid, rob_full, rs_full} = '0;
		{result_valid, result_mis_pred, result_cond_branch, result_uncond_branch} = '0;
		{result_taken, result_local_taken, result_global_taken, probe_en} = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = make_inst();
		mem[branch_x[9:2]] = 32'h00208063;  // beq x1, x2
		mem[jal_y[9:2]] = 32'h010000ef;     // jal x1, 16
		repeat (4) @(posedge clock);
		reset <= 0;
		repeat (random_cycles) begin
			@(posedge clock);
			drive_random();
		end
		// learning: fresh tables, then six taken resolutions of x
		@(posedge clock);
		quiet_inputs();
		reset <= 1;
		repeat (4) @(posedge clock);
		reset <= 0;
		repeat (6)
			resolve_taken(branch_x, target_t, 1'b1);
		redirect_to(branch_x);
		probe_next(target_t, 1'b1);
		redirect_to(jal_y);
		probe_next(jal_y + 32'd4, 1'b0);     // untrained jump falls through
		resolve_taken(jal_y, target_j, 1'b0);
		redirect_to(jal_y);
		probe_next(target_j, 1'b0);
		repeat (2) @(posedge clock);
		total_errors = error_count + u_dut.u_assertions.fail_count;
		$display("checks run %0d, errors %0d, assertion failures %0d",
			check_count, error_count, u_dut.u_assertions.fail_count);
		if (total_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* verilog/branch_predictor.sv */
// tournament predictor; update indices come from the current histories,
// not from those seen at fetch, so a late update lands close but not exact
module branch_predictor (
	input  logic                          clock,
	input  logic                          reset,
	input  logic [frontend_pkg::xlen-1:0] pc,
	input  logic                          update_en,      // valid cond branch resolved
	input  logic [frontend_pkg::xlen-1:0] update_pc,
	input  logic                          update_taken,
	input  logic                          update_local_taken,
	input  logic                          update_global_taken,
	output logic                          pred_taken,
	output logic                          local_taken,
	output logic                          global_taken
);
	localparam int lidx_w = $clog2(frontend_pkg::bht_entries);
	localparam int lh_w = frontend_pkg::local_hist_width;
	localparam int gh_w = frontend_pkg::ghist_width;

	logic [lh_w-1:0] local_hist [frontend_pkg::bht_entries]; // per-pc histories
	logic [1:0]      local_cnt [2**lh_w];                    // indexed by history
	logic [1:0]      global_cnt [2**gh_w];                   // gshare counters
	logic [1:0]      chooser [frontend_pkg::bht_entries];    // msb set picks global
	logic [gh_w-1:0] ghist;

	logic [lidx_w-1:0] lidx;
	logic [gh_w-1:0]   gidx;
	logic [lidx_w-1:0] upd_lidx;
	logic [gh_w-1:0]   upd_gidx;
	logic [lh_w-1:0]   upd_lhist;

	// saturating 2-bit step
	function automatic logic [1:0] sat_step(input logic [1:0] cnt, input logic up);
		if (up)
			return (cnt == 2'b11) ? cnt : cnt + 2'b01;
		return (cnt == 2'b00) ? cnt : cnt - 2'b01;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// lookup
	assign lidx = pc[lidx_w+1:2];                // word index, low bits dropped
	assign gidx = pc[gh_w+1:2] ^ ghist;
	assign local_taken = local_cnt[local_hist[lidx]][1];
	assign global_taken = global_cnt[gidx][1];
	assign pred_taken = chooser[lidx][1] ? global_taken : local_taken;

	////////////////////////////////////////////////////////////////////////////
	// training
	assign upd_lidx = update_pc[lidx_w+1:2];
	assign upd_gidx = update_pc[gh_w+1:2] ^ ghist;
	assign upd_lhist = local_hist[upd_lidx];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < frontend_pkg::bht_entries; i++) begin
				local_hist[i] <= '0;
				chooser[i] <= 2'b01;                 // weakly local
			end
			for (int i = 0; i < 2**lh_w; i++)
				local_cnt[i] <= 2'b01;               // weakly not taken
			for (int i = 0; i < 2**gh_w; i++)
				global_cnt[i] <= 2'b01;
			ghist <= '0;
		end else if (update_en) begin
			local_cnt[upd_lhist] <= sat_step(local_cnt[upd_lhist], update_taken);
			global_cnt[upd_gidx] <= sat_step(global_cnt[upd_gidx], update_taken);
			// chooser moves only on disagreement, towards the correct side
			if (update_local_taken != update_global_taken)
				chooser[upd_lidx] <= sat_step(chooser[upd_lidx],
					update_global_taken == update_taken);
			local_hist[upd_lidx] <= {upd_lhist[lh_w-2:0], update_taken};
			ghist <= {ghist[gh_w-2:0], update_taken}; // newest outcome in lsb
		end
	end

endmodule

/* verilog/branch_target_buffer.sv */
// direct mapped, one target per entry; a later taken branch aliasing to the
// same index replaces the earlier one
module branch_target_buffer (
	input  logic                          clock,
	input  logic                          reset,
	input  logic [frontend_pkg::xlen-1:0] pc,
	input  logic                          update_en,      // taken branch or jump
	input  logic [frontend_pkg::xlen-1:0] update_pc,
	input  logic [frontend_pkg::xlen-1:0] update_target,
	output logic                          hit,
	output logic [frontend_pkg::xlen-1:0] target
);
	localparam int idx_w = $clog2(frontend_pkg::btb_entries);
	localparam int tag_w = frontend_pkg::xlen - idx_w - 2;

	logic [frontend_pkg::btb_entries-1:0] valid;
	logic [tag_w-1:0]              tags [frontend_pkg::btb_entries];
	logic [frontend_pkg::xlen-1:0] targets [frontend_pkg::btb_entries];

	logic [idx_w-1:0] idx;
	logic [idx_w-1:0] upd_idx;

	assign idx = pc[idx_w+1:2];
	assign upd_idx = update_pc[idx_w+1:2];

	////////////////////////////////////////////////////////////////////////////
	// lookup
	assign hit = valid[idx] && (tags[idx] == pc[frontend_pkg::xlen-1:idx_w+2]);
	assign target = targets[idx];                // meaningful only with hit

	////////////////////////////////////////////////////////////////////////////
	// write on taken resolution
	always_ff @(posedge clock) begin
		if (reset)
			valid <= '0;                         // whole buffer empty
		else if (update_en)
			valid[upd_idx] <= 1'b1;
	end

	always_ff @(posedge clock) begin
		if (update_en) begin
			tags[upd_idx] <= update_pc[frontend_pkg::xlen-1:idx_w+2];
			targets[upd_idx] <= update_target;
		end
	end

endmodule

/* verilog/fetch_decode_stage.sv */
// one instruction per cycle; the cache answers in the same cycle it is asked
// a back end mispredict wins over any stall and redirects on the next edge
module fetch_decode_stage (
	input  logic                                      clock,
	input  logic                                      reset,
	input  logic                                      rob_full,
	input  logic [3:0]                                rs_full,    // one bit per fu_type_t
	input  logic [frontend_pkg::xlen-1:0]             icache_data,
	input  logic                                      icache_valid,
	input  logic [frontend_pkg::xlen-1:0]             result_pc,
	input  logic                                      result_cond_branch,
	input  logic                                      result_uncond_branch,
	input  logic                                      result_taken,
	input  logic [frontend_pkg::xlen-1:0]             result_target_pc,
	input  logic                                      result_local_taken,
	input  logic                                      result_global_taken,
	input  logic                                      result_mis_pred,
	input  logic                                      result_valid,
	output logic [frontend_pkg::xlen-1:0]             icache_addr,
	output logic                                      id_valid,
	output logic [frontend_pkg::xlen-1:0]             id_inst,
	output logic [frontend_pkg::xlen-1:0]             id_pc,
	output logic [frontend_pkg::xlen-1:0]             id_npc,
	output frontend_pkg::opa_sel_t                    id_opa_select,
	output frontend_pkg::opb_sel_t                    id_opb_select,
	output frontend_pkg::alu_func_t                   id_alu_func,
	output frontend_pkg::fu_type_t                    id_fu_type,
	output logic [frontend_pkg::areg_idx_width-1:0]   id_rs1_idx,
	output logic [frontend_pkg::areg_idx_width-1:0]   id_rs2_idx,
	output logic [frontend_pkg::areg_idx_width-1:0]   id_dest_idx,
	output logic                                      id_rd_mem,
	output logic                                      id_wr_mem,
	output logic                                      id_cond_branch,
	output logic                                      id_uncond_branch,
	output logic                                      id_csr_op,
	output logic                                      id_halt,
	output logic                                      id_illegal,
	output logic                                      id_local_taken,
	output logic                                      id_global_taken,
	output logic                                      id_branch_prediction
);
	logic [frontend_pkg::xlen-1:0] pc_reg;
	logic [frontend_pkg::xlen-1:0] btb_target;
	logic                          btb_hit;
	logic                          pred_taken;
	logic                          dest_valid;
	logic                          redirect;                // valid mispredict
	logic                          predict_jump;

	assign redirect = result_valid && result_mis_pred;

	////////////////////////////////////////////////////////////////////////////
	// prediction, trained by resolved results
	branch_predictor u_predictor (
		.clock(clock), .reset(reset), .pc(pc_reg),
		.update_en(result_valid && result_cond_branch),
		.update_pc(result_pc), .update_taken(result_taken),
		.update_local_taken(result_local_taken), .update_global_taken(result_global_taken),
		.pred_taken(pred_taken), .local_taken(id_local_taken), .global_taken(id_global_taken)
	);

	branch_target_buffer u_btb (
		.clock(clock), .reset(reset), .pc(pc_reg),
		.update_en(result_valid && result_taken && (result_cond_branch || result_uncond_branch)),
		.update_pc(result_pc), .update_target(result_target_pc),
		.hit(btb_hit), .target(btb_target)
	);

	////////////////////////////////////////////////////////////////////////////
	// decode
	inst_decoder u_decoder (
		.inst(icache_data), .opa_select(id_opa_select), .opb_select(id_opb_select),
		.alu_func(id_alu_func), .fu_type(id_fu_type), .dest_valid(dest_valid),
		.rd_mem(id_rd_mem), .wr_mem(id_wr_mem), .cond_branch(id_cond_branch),
		.uncond_branch(id_uncond_branch), .csr_op(id_csr_op), .halt(id_halt),
		.illegal(id_illegal)
	);

	assign icache_addr = {pc_reg[frontend_pkg::xlen-1:2], 2'b00}; // word aligned
	assign id_inst = icache_data;
	assign id_pc = pc_reg;
	assign id_rs1_idx = icache_data[19:15];
	assign id_rs2_idx = icache_data[24:20];
	assign id_dest_idx = dest_valid ? icache_data[11:7] : frontend_pkg::zero_reg;
	assign id_branch_prediction = btb_hit && pred_taken;

	// a jump with no btb entry yet falls through to pc + 4
	assign predict_jump = ((id_cond_branch && pred_taken) || id_uncond_branch) && btb_hit;
	assign id_npc = predict_jump ? btb_target : pc_reg + 32'd4;

	assign id_valid = icache_valid && !redirect && !rob_full && !rs_full[id_fu_type];

	////////////////////////////////////////////////////////////////////////////
	// pc register
	always_ff @(posedge clock) begin
		if (reset)
			pc_reg <= '0;
		else if (redirect)
			pc_reg <= result_target_pc;          // back end correction first
		else if (id_valid)
			pc_reg <= id_npc;                    // stalls leave the pc alone
	end

endmodule

/* verilog/frontend_pkg.sv */
// widths, encodings and table sizes shared by the front end and its testbench
// RV32I only: no compressed encodings, csr side effects are left to the back end
package frontend_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	localparam int xlen = 32;                  // data and address width
	localparam int areg_idx_width = 5;         // architectural register index
	localparam logic [areg_idx_width-1:0] zero_reg = '0; // x0, no writeback

	////////////////////////////////////////////////////////////////////////////
	// decode encodings
	typedef enum logic [1:0] {
		fu_alu    = 2'd0,
		fu_mem    = 2'd1,
		fu_branch = 2'd2,
		fu_mult   = 2'd3                        // also the index into rs_full
	} fu_type_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or,
		alu_xor, alu_sll, alu_srl, alu_sra, alu_copy_b
	} alu_func_t;

	typedef enum logic [1:0] {
		opa_is_rs1, opa_is_pc, opa_is_zero
	} opa_sel_t;

	typedef enum logic [2:0] {
		opb_is_rs2, opb_is_i_imm, opb_is_s_imm, opb_is_b_imm, opb_is_u_imm, opb_is_j_imm
	} opb_sel_t;

	////////////////////////////////////////////////////////////////////////////
	// prediction tables
	localparam int bht_entries = 64;           // local history table, pc indexed
	localparam int local_hist_width = 4;
	localparam int ghist_width = 6;            // also sets gshare table size
	localparam int btb_entries = 32;

	// major opcodes, inst[6:0]
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_system = 7'b1110011;

endpackage

/* verilog/inst_decoder.sv */
// RV32I plus M register ops; fence and unknown encodings come out illegal
module inst_decoder (
	input  logic [frontend_pkg::xlen-1:0] inst,
	output frontend_pkg::opa_sel_t        opa_select,
	output frontend_pkg::opb_sel_t        opb_select,
	output frontend_pkg::alu_func_t       alu_func,
	output frontend_pkg::fu_type_t        fu_type,
	output logic                          dest_valid,
	output logic                          rd_mem,
	output logic                          wr_mem,
	output logic                          cond_branch,
	output logic                          uncond_branch,
	output logic                          csr_op,
	output logic                          halt,
	output logic                          illegal
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb begin
		opa_select = frontend_pkg::opa_is_rs1;
		opb_select = frontend_pkg::opb_is_rs2;
		alu_func = frontend_pkg::alu_add;
		fu_type = frontend_pkg::fu_alu;
		dest_valid = 1'b0;
		rd_mem = 1'b0;
		wr_mem = 1'b0;
		cond_branch = 1'b0;
		uncond_branch = 1'b0;
		csr_op = 1'b0;
		halt = 1'b0;
		illegal = 1'b0;
		case (opcode)
			frontend_pkg::op_lui: begin
				opa_select = frontend_pkg::opa_is_zero;
				opb_select = frontend_pkg::opb_is_u_imm;
				dest_valid = 1'b1;
			end
			frontend_pkg::op_auipc: begin
				opa_select = frontend_pkg::opa_is_pc;
				opb_select = frontend_pkg::opb_is_u_imm;
				dest_valid = 1'b1;
			end
			frontend_pkg::op_jal: begin
				opa_select = frontend_pkg::opa_is_pc;
				opb_select = frontend_pkg::opb_is_j_imm;
				fu_type = frontend_pkg::fu_branch;
				uncond_branch = 1'b1;
				dest_valid = 1'b1;               // link register
			end
			frontend_pkg::op_jalr: begin
				opb_select = frontend_pkg::opb_is_i_imm;
				fu_type = frontend_pkg::fu_branch;
				uncond_branch = 1'b1;
				dest_valid = 1'b1;
				illegal = (funct3 != 3'b000);
			end
			frontend_pkg::op_branch: begin
				opa_select = frontend_pkg::opa_is_pc;    // target is pc + b_imm
				opb_select = frontend_pkg::opb_is_b_imm;
				fu_type = frontend_pkg::fu_branch;
				cond_branch = 1'b1;
				illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
			end
			frontend_pkg::op_load: begin
				opb_select = frontend_pkg::opb_is_i_imm;
				fu_type = frontend_pkg::fu_mem;
				rd_mem = 1'b1;
				dest_valid = 1'b1;
				illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11); // no ld, lwu
			end
			frontend_pkg::op_store: begin
				opb_select = frontend_pkg::opb_is_s_imm;
				fu_type = frontend_pkg::fu_mem;
				wr_mem = 1'b1;
				illegal = (funct3[2] || funct3 == 3'b011);
			end
			frontend_pkg::op_imm, frontend_pkg::op_reg: begin
				if (opcode == frontend_pkg::op_imm)
					opb_select = frontend_pkg::opb_is_i_imm;
				dest_valid = 1'b1;
				case (funct3)
					3'b000: alu_func = (opcode == frontend_pkg::op_reg && funct7[5]) ?
						frontend_pkg::alu_sub : frontend_pkg::alu_add;
					3'b001: alu_func = frontend_pkg::alu_sll;
					3'b010: alu_func = frontend_pkg::alu_slt;
					3'b011: alu_func = frontend_pkg::alu_sltu;
					3'b100: alu_func = frontend_pkg::alu_xor;
					3'b101: alu_func = funct7[5] ? frontend_pkg::alu_sra : frontend_pkg::alu_srl;
					3'b110: alu_func = frontend_pkg::alu_or;
					default: alu_func = frontend_pkg::alu_and;
				endcase
				// funct7 only matters for shifts and register ops
				if (opcode == frontend_pkg::op_reg && funct7 == 7'b0000001)
					fu_type = frontend_pkg::fu_mult;     // mul/div family
				else if (opcode == frontend_pkg::op_reg || funct3[1:0] == 2'b01)
					illegal = (funct7 != 7'b0000000) && !(funct7 == 7'b0100000 &&
						(funct3 == 3'b101 || (funct3 == 3'b000 && opcode == frontend_pkg::op_reg)));
			end
			frontend_pkg::op_system: begin
				if (funct3 == 3'b000) begin
					// ecall is all zero above the opcode, ebreak sets bit 20
					halt = (inst[31:21] == '0) && (inst[19:7] == '0);
					illegal = !halt;
				end else begin
					csr_op = 1'b1;
					dest_valid = 1'b1;
					illegal = (funct3 == 3'b100);
				end
			end
			default: illegal = 1'b1;
		endcase
		if (illegal) begin                   // nothing may reach memory or the pc
			rd_mem = 1'b0;
			wr_mem = 1'b0;
			cond_branch = 1'b0;
			uncond_branch = 1'b0;
			dest_valid = 1'b0;
			csr_op = 1'b0;
		end
	end

endmodule
